// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_exec_stage
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
design/exec_pkg.sv
design/issue_latch.sv
design/exec_lane.sv
design/branch_unit.sv
design/muldiv_unit.sv
design/exec_resolve.sv
design/exec_stage.sv
verification/exec_checker.sv
verification/tb_exec_stage.sv

// File: design/branch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module branch_unit (
    input  logic                valid_i,
    input  exec_pkg::op_e       op_i,
    input  exec_pkg::word_t     rs_i,
    input  exec_pkg::word_t     rt_i,
    input  logic [15:0]         imm_i,
    input  exec_pkg::word_t     pc_i,
    input  logic [25:0]         jidx_i,
    input  logic                pred_i,
    output logic                redirect_o,
    output exec_pkg::word_t     redirect_pc_o,
    output exec_pkg::word_t     link_o
);
    import exec_pkg::*;

    logic  is_cond;
    logic  cond;
    word_t pc4;
    word_t br_target;
    word_t j_target;

    assign pc4 = pc_i + word_t'(4);
    assign br_target = pc4 + {{(XLEN-18){imm_i[15]}}, imm_i, 2'b00};
    assign j_target = {pc4[XLEN-1:XLEN-4], jidx_i, 2'b00};
    // return address skips the delay slot
    assign link_o = pc_i + word_t'(8);
    assign is_cond = op_i inside {BEQ, BNE, BLTZ, BGEZ};

    always_comb begin
        case (op_i)
            BEQ:     cond = (rs_i == rt_i);
            BNE:     cond = (rs_i != rt_i);
            BLTZ:    cond = rs_i[XLEN-1];
            BGEZ:    cond = !rs_i[XLEN-1];
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        redirect_o = 1'b0;
        redirect_pc_o = '0;
        if (valid_i && is_branch(op_i)) begin
            if (is_cond && cond && !pred_i) begin
                redirect_o = 1'b1;
                redirect_pc_o = br_target;
            end else if (is_cond && !cond && pred_i) begin
                redirect_o = 1'b1;
                redirect_pc_o = link_o;
            end else if ((op_i == JR) && !pred_i) begin
                redirect_o = 1'b1;
                redirect_pc_o = rs_i;
            end else if ((op_i inside {J, JAL}) && !pred_i) begin
                redirect_o = 1'b1;
                redirect_pc_o = j_target;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/exec_lane.sv
`timescale 1ns/1ns
`default_nettype none

module exec_lane (
    input  logic                valid_i,
    input  exec_pkg::op_e       op_i,
    input  exec_pkg::word_t     rs_i,
    input  exec_pkg::word_t     rt_i,
    input  logic [15:0]         imm_i,
    input  logic [4:0]          shamt_i,
    output exec_pkg::word_t     result_o,
    output logic                ovf_o,
    output logic                misalign_o,
    output logic                load_o,
    output logic                store_o
);
    import exec_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t sum;
    word_t diff;
    logic  add_ovf;
    logic  sub_ovf;
    logic  half_acc;
    logic  word_acc;

    assign op_a = (op_i inside {SLL, SRL, SRA}) ? {{(XLEN-5){1'b0}}, shamt_i} : rs_i;
    // logical immediates zero extend
    assign op_b = !uses_imm(op_i)                ? rt_i :
                  (op_i inside {ANDI, ORI, XORI}) ? {16'b0, imm_i} :
                                                    {{16{imm_i[15]}}, imm_i};

    assign sum = op_a + op_b;
    assign diff = op_a - op_b;
    assign add_ovf = (op_a[XLEN-1] == op_b[XLEN-1]) && (sum[XLEN-1] != op_a[XLEN-1]);
    assign sub_ovf = (op_a[XLEN-1] != op_b[XLEN-1]) && (diff[XLEN-1] != op_a[XLEN-1]);

    always_comb begin
        case (op_i)
            ADD, ADDU, ADDI, ADDIU, LW, LH, LB, SW, SH, SB: result_o = sum;
            SUB, SUBU:  result_o = diff;
            AND, ANDI:  result_o = op_a & op_b;
            OR, ORI:    result_o = op_a | op_b;
            XOR, XORI:  result_o = op_a ^ op_b;
            NOR:        result_o = ~(op_a | op_b);
            SLT, SLTI:  result_o = word_t'($signed(op_a) < $signed(op_b));
            SLTU:       result_o = word_t'(op_a < op_b);
            SLL:        result_o = op_b << op_a[4:0];
            SRL:        result_o = op_b >> op_a[4:0];
            SRA:        result_o = word_t'($signed(op_b) >>> op_a[4:0]);
            LUI:        result_o = {op_b[15:0], 16'b0};
            default:    result_o = '0;
        endcase
    end

    assign ovf_o = valid_i && (((op_i inside {ADD, ADDI}) && add_ovf) ||
                               ((op_i == SUB) && sub_ovf));

    assign load_o = valid_i && is_load(op_i);
    assign store_o = valid_i && is_store(op_i);

    // address is the sum
    assign half_acc = op_i inside {LH, SH};
    assign word_acc = op_i inside {LW, SW};
    assign misalign_o = (load_o || store_o) &&
                        ((half_acc && sum[0]) || (word_acc && (sum[1:0] != 2'b00)));

endmodule

`default_nettype wire

// File: design/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int XLEN = 32;
    localparam int NUM_SLOTS = 2;
    localparam int MULDIV_STEPS = 32;
    localparam int MD_CNT_W = $clog2(MULDIV_STEPS);

    typedef logic [XLEN-1:0] word_t;
    typedef logic [2*XLEN-1:0] dword_t;

    typedef enum logic [5:0] {
        OP_NOP,
        ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
        SLL, SRL, SRA,
        ADDI, ADDIU, ANDI, ORI, XORI, SLTI, LUI,
        LW, LH, LB, SW, SH, SB,
        BEQ, BNE, BLTZ, BGEZ, J, JAL, JR,
        MULT, MULTU, DIV, DIVU
    } op_e;

    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_OV,
        EXC_ADEL,
        EXC_ADES
    } exc_e;

    function automatic logic is_muldiv(op_e op);
        return op inside {MULT, MULTU, DIV, DIVU};
    endfunction

    // jumps count as branches and only slot 1 may carry them
    function automatic logic is_branch(op_e op);
        return op inside {BEQ, BNE, BLTZ, BGEZ, J, JAL, JR};
    endfunction

    function automatic logic is_load(op_e op);
        return op inside {LW, LH, LB};
    endfunction

    function automatic logic is_store(op_e op);
        return op inside {SW, SH, SB};
    endfunction

    function automatic logic uses_imm(op_e op);
        return op inside {ADDI, ADDIU, ANDI, ORI, XORI, SLTI, LUI,
                          LW, LH, LB, SW, SH, SB};
    endfunction

endpackage

`default_nettype wire

// File: design/exec_resolve.sv
`timescale 1ns/1ns
`default_nettype none

module exec_resolve (
    input  logic                    stall_i,
    input  logic [1:0]              valid_i,
    input  exec_pkg::op_e [1:0]     op_i,
    input  exec_pkg::word_t [1:0]   lane_result_i,
    input  logic [1:0]              lane_ovf_i,
    input  logic [1:0]              lane_misalign_i,
    input  logic [1:0]              lane_load_i,
    input  logic [1:0]              lane_store_i,
    input  exec_pkg::word_t         link_i,
    input  logic                    md_done_i,
    input  exec_pkg::dword_t        md_hilo_i,
    output logic [1:0]              res_valid_o,
    output exec_pkg::word_t [1:0]   res_data_o,
    output logic [1:0]              mem_rd_o,
    output logic [1:0]              mem_wr_o,
    output exec_pkg::exc_e [1:0]    exc_o,
    output exec_pkg::word_t [1:0]   badvaddr_o,
    output logic                    hilo_we_o,
    output exec_pkg::dword_t        hilo_o,
    output logic                    stall_o
);
    import exec_pkg::*;

    logic [1:0] live;
    logic [1:0] mem_ok;

    // slot 1 overflow squashes the younger slot
    assign live[1] = valid_i[1] && !stall_i;
    assign live[0] = valid_i[0] && !stall_i && !lane_ovf_i[1];
    assign res_valid_o = live;

    // a misaligned slot 1 keeps slot 0 off the bus as well
    assign mem_ok[1] = live[1] && !lane_misalign_i[1];
    assign mem_ok[0] = live[0] && !lane_misalign_i[0] && !lane_misalign_i[1];
    assign mem_rd_o = lane_load_i & mem_ok;
    assign mem_wr_o = lane_store_i & mem_ok;

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            res_data_o[i] = (op_i[i] == JAL) ? link_i : lane_result_i[i];
            exc_o[i] = EXC_NONE;
            badvaddr_o[i] = '0;
            if (live[i] && lane_misalign_i[i]) begin
                exc_o[i] = lane_load_i[i] ? EXC_ADEL : EXC_ADES;
                badvaddr_o[i] = lane_result_i[i];
            end else if (live[i] && lane_ovf_i[i]) begin
                exc_o[i] = EXC_OV;
            end
        end
    end

    assign stall_o = stall_i;
    assign hilo_we_o = md_done_i;
    assign hilo_o = md_hilo_i;

    always_comb begin
        if (md_done_i) begin
            assert (!stall_i)
                else $error("hi/lo write while the stage is stalled");
        end
    end

endmodule

`default_nettype wire

// File: design/exec_stage.sv
`timescale 1ns/1ns
`default_nettype none

module exec_stage (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic [1:0]              iss_valid_i,
    input  exec_pkg::op_e [1:0]     iss_op_i,
    input  exec_pkg::word_t [1:0]   iss_rs_i,
    input  exec_pkg::word_t [1:0]   iss_rt_i,
    input  logic [1:0][15:0]        iss_imm_i,
    input  logic [1:0][4:0]         iss_shamt_i,
    input  exec_pkg::word_t         iss_pc_i,
    input  logic [25:0]             iss_jidx_i,
    input  logic                    iss_pred_taken_i,
    output logic [1:0]              res_valid_o,
    output exec_pkg::word_t [1:0]   res_data_o,
    output logic [1:0]              mem_rd_o,
    output logic [1:0]              mem_wr_o,
    output exec_pkg::exc_e [1:0]    exc_o,
    output exec_pkg::word_t [1:0]   badvaddr_o,
    output logic                    redirect_o,
    output exec_pkg::word_t         redirect_pc_o,
    output logic                    hilo_we_o,
    output exec_pkg::dword_t        hilo_o,
    output logic                    stall_o
);
    import exec_pkg::*;

    logic [1:0]         l_valid;
    op_e [1:0]          l_op;
    word_t [1:0]        l_rs;
    word_t [1:0]        l_rt;
    logic [1:0][15:0]   l_imm;
    logic [1:0][4:0]    l_shamt;
    word_t              l_pc;
    logic [25:0]        l_jidx;
    logic               l_pred;
    word_t [1:0]        lane_result;
    logic [1:0]         lane_ovf;
    logic [1:0]         lane_misalign;
    logic [1:0]         lane_load;
    logic [1:0]         lane_store;
    word_t              link;
    logic               md_busy;
    logic               md_done;
    dword_t             md_hilo;

    issue_latch u_latch (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .stall_i          (md_busy),
        .iss_valid_i      (iss_valid_i),
        .iss_op_i         (iss_op_i),
        .iss_rs_i         (iss_rs_i),
        .iss_rt_i         (iss_rt_i),
        .iss_imm_i        (iss_imm_i),
        .iss_shamt_i      (iss_shamt_i),
        .iss_pc_i         (iss_pc_i),
        .iss_jidx_i       (iss_jidx_i),
        .iss_pred_taken_i (iss_pred_taken_i),
        .l_valid_o        (l_valid),
        .l_op_o           (l_op),
        .l_rs_o           (l_rs),
        .l_rt_o           (l_rt),
        .l_imm_o          (l_imm),
        .l_shamt_o        (l_shamt),
        .l_pc_o           (l_pc),
        .l_jidx_o         (l_jidx),
        .l_pred_o         (l_pred)
    );

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_lane
        exec_lane u_lane (
            .valid_i    (l_valid[i]),
            .op_i       (l_op[i]),
            .rs_i       (l_rs[i]),
            .rt_i       (l_rt[i]),
            .imm_i      (l_imm[i]),
            .shamt_i    (l_shamt[i]),
            .result_o   (lane_result[i]),
            .ovf_o      (lane_ovf[i]),
            .misalign_o (lane_misalign[i]),
            .load_o     (lane_load[i]),
            .store_o    (lane_store[i])
        );
    end

    // branches only ever sit in slot 1
    branch_unit u_branch (
        .valid_i       (l_valid[1]),
        .op_i          (l_op[1]),
        .rs_i          (l_rs[1]),
        .rt_i          (l_rt[1]),
        .imm_i         (l_imm[1]),
        .pc_i          (l_pc),
        .jidx_i        (l_jidx),
        .pred_i        (l_pred),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .link_o        (link)
    );

    muldiv_unit u_muldiv (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (l_valid),
        .op_i    (l_op),
        .rs_i    (l_rs),
        .rt_i    (l_rt),
        .busy_o  (md_busy),
        .done_o  (md_done),
        .hilo_o  (md_hilo)
    );

    exec_resolve u_resolve (
        .stall_i         (md_busy),
        .valid_i         (l_valid),
        .op_i            (l_op),
        .lane_result_i   (lane_result),
        .lane_ovf_i      (lane_ovf),
        .lane_misalign_i (lane_misalign),
        .lane_load_i     (lane_load),
        .lane_store_i    (lane_store),
        .link_i          (link),
        .md_done_i       (md_done),
        .md_hilo_i       (md_hilo),
        .res_valid_o     (res_valid_o),
        .res_data_o      (res_data_o),
        .mem_rd_o        (mem_rd_o),
        .mem_wr_o        (mem_wr_o),
        .exc_o           (exc_o),
        .badvaddr_o      (badvaddr_o),
        .hilo_we_o       (hilo_we_o),
        .hilo_o          (hilo_o),
        .stall_o         (stall_o)
    );

endmodule

`default_nettype wire

// File: design/issue_latch.sv
`timescale 1ns/1ns
`default_nettype none

module issue_latch (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    stall_i,
    input  logic [1:0]              iss_valid_i,
    input  exec_pkg::op_e [1:0]     iss_op_i,
    input  exec_pkg::word_t [1:0]   iss_rs_i,
    input  exec_pkg::word_t [1:0]   iss_rt_i,
    input  logic [1:0][15:0]        iss_imm_i,
    input  logic [1:0][4:0]         iss_shamt_i,
    input  exec_pkg::word_t         iss_pc_i,
    input  logic [25:0]             iss_jidx_i,
    input  logic                    iss_pred_taken_i,
    output logic [1:0]              l_valid_o,
    output exec_pkg::op_e [1:0]     l_op_o,
    output exec_pkg::word_t [1:0]   l_rs_o,
    output exec_pkg::word_t [1:0]   l_rt_o,
    output logic [1:0][15:0]        l_imm_o,
    output logic [1:0][4:0]         l_shamt_o,
    output exec_pkg::word_t         l_pc_o,
    output logic [25:0]             l_jidx_o,
    output logic                    l_pred_o
);
    import exec_pkg::*;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            l_valid_o <= 2'b00;
            l_op_o[1] <= OP_NOP;
            l_op_o[0] <= OP_NOP;
            l_pred_o <= 1'b0;
        end else if (!stall_i) begin
            l_valid_o <= iss_valid_i;
            l_op_o <= iss_op_i;
            l_pred_o <= iss_pred_taken_i;
        end
    end

    // operands and pc
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            l_rs_o <= iss_rs_i;
            l_rt_o <= iss_rt_i;
            l_imm_o <= iss_imm_i;
            l_shamt_o <= iss_shamt_i;
            l_pc_o <= iss_pc_i;
            l_jidx_o <= iss_jidx_i;
        end
    end

    a_slot0_no_branch: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        l_valid_o[0] |-> !is_branch(l_op_o[0])
    ) else $error("branch or jump latched into slot 0");

endmodule

`default_nettype wire

// File: design/muldiv_unit.sv
`timescale 1ns/1ns
`default_nettype none

module muldiv_unit (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic [1:0]              valid_i,
    input  exec_pkg::op_e [1:0]     op_i,
    input  exec_pkg::word_t [1:0]   rs_i,
    input  exec_pkg::word_t [1:0]   rt_i,
    output logic                    busy_o,
    output logic                    done_o,
    output exec_pkg::dword_t        hilo_o
);
    import exec_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } state_e;

    state_e                state_q;
    logic [MD_CNT_W-1:0]   cnt_q;
    logic [1:0]            req;
    logic                  sel;
    logic                  start;
    logic                  sgn;
    word_t                 a_mag;
    word_t                 b_mag;
    logic                  is_div_q;
    logic                  neg_a_q;
    logic                  neg_b_q;
    word_t                 b_q;
    word_t                 hi_q;
    word_t                 lo_q;
    logic [XLEN:0]         add_sum;
    logic [XLEN:0]         rem_sh;
    logic                  rem_ge;
    dword_t                prod;

    assign req[1] = valid_i[1] && is_muldiv(op_i[1]);
    assign req[0] = valid_i[0] && is_muldiv(op_i[0]);
    // older slot first
    assign sel = req[1];
    assign start = (state_q == IDLE) && (req != 2'b00);
    assign sgn = op_i[sel] inside {MULT, DIV};
    assign a_mag = (sgn && rs_i[sel][XLEN-1]) ? -rs_i[sel] : rs_i[sel];
    assign b_mag = (sgn && rt_i[sel][XLEN-1]) ? -rt_i[sel] : rt_i[sel];

    // one shift-add or restoring-subtract step per cycle
    assign add_sum = lo_q[0] ? ({1'b0, hi_q} + {1'b0, b_q}) : {1'b0, hi_q};
    assign rem_sh = {hi_q, lo_q[XLEN-1]};
    assign rem_ge = (rem_sh >= {1'b0, b_q});

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            cnt_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start) begin
                        state_q <= RUN;
                        cnt_q <= '0;
                    end
                end
                RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == MD_CNT_W'(MULDIV_STEPS - 1)) begin
                        state_q <= DONE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            is_div_q <= op_i[sel] inside {DIV, DIVU};
            neg_a_q <= sgn && rs_i[sel][XLEN-1];
            neg_b_q <= sgn && rt_i[sel][XLEN-1];
            b_q <= b_mag;
            hi_q <= '0;
            lo_q <= a_mag;
        end else if (state_q == RUN) begin
            if (is_div_q) begin
                hi_q <= rem_ge ? word_t'(rem_sh - {1'b0, b_q}) : rem_sh[XLEN-1:0];
                lo_q <= {lo_q[XLEN-2:0], rem_ge};
            end else begin
                hi_q <= add_sum[XLEN:1];
                lo_q <= {add_sum[0], lo_q[XLEN-1:1]};
            end
        end
    end

    // remainder takes the sign of the dividend
    assign prod = {hi_q, lo_q};
    always_comb begin
        if (is_div_q) begin
            hilo_o[XLEN-1:0] = (neg_a_q ^ neg_b_q) ? -lo_q : lo_q;
            hilo_o[2*XLEN-1:XLEN] = neg_a_q ? -hi_q : hi_q;
        end else begin
            hilo_o = (neg_a_q ^ neg_b_q) ? -prod : prod;
        end
    end

    assign busy_o = start || (state_q == RUN);
    assign done_o = (state_q == DONE);

    a_single_request: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !(req[1] && req[0])
    ) else $error("both slots requested mul/div");

endmodule

`default_nettype wire

// File: verification/exec_checker.sv
`timescale 1ns/1ns
`default_nettype none

module exec_checker (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    chk_en_i,
    input  logic [1:0]              exp_valid_i,
    input  exec_pkg::word_t [1:0]   exp_data_i,
    input  logic [1:0]              exp_rd_i,
    input  logic [1:0]              exp_wr_i,
    input  logic [1:0][1:0]         exp_exc_i,
    input  exec_pkg::word_t [1:0]   exp_bad_i,
    input  logic                    exp_redir_i,
    input  exec_pkg::word_t         exp_rpc_i,
    input  int                      exp_stall_i,
    input  logic                    exp_hwe_i,
    input  exec_pkg::dword_t        exp_hilo_i,
    input  logic [1:0]              res_valid_i,
    input  exec_pkg::word_t [1:0]   res_data_i,
    input  logic [1:0]              mem_rd_i,
    input  logic [1:0]              mem_wr_i,
    input  exec_pkg::exc_e [1:0]    exc_i,
    input  exec_pkg::word_t [1:0]   badvaddr_i,
    input  logic                    redirect_i,
    input  exec_pkg::word_t         redirect_pc_i,
    input  logic                    hilo_we_i,
    input  exec_pkg::dword_t        hilo_i,
    input  logic                    stall_i,
    output int                      err_cnt_o
);
    import exec_pkg::*;

    int errs = 0;
    int stall_cnt = 0;

    assign err_cnt_o = errs;

    task automatic check_val(string name, logic [63:0] exp, logic [63:0] act);
        if (exp !== act) begin
            $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            errs++;
        end
    endtask

    // outputs are sampled before the latch moves on
    always @(posedge clk) begin
        if (!rst_n_i) begin
            stall_cnt = 0;
        end else if (stall_i) begin
            stall_cnt++;
            check_val("res_valid_o during stall", 64'(2'b00), 64'(res_valid_i));
            check_val("hilo_we_o during stall", 64'(1'b0), 64'(hilo_we_i));
        end else if (chk_en_i) begin
            check_val("stall_o cycle count", 64'(exp_stall_i), 64'(stall_cnt));
            stall_cnt = 0;
            check_val("res_valid_o", 64'(exp_valid_i), 64'(res_valid_i));
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (exp_valid_i[i]) begin
                    check_val($sformatf("res_data_o[%0d]", i), 64'(exp_data_i[i]),
                              64'(res_data_i[i]));
                end
                check_val($sformatf("exc_o[%0d]", i), 64'(exp_exc_i[i]), 64'(exc_i[i]));
                check_val($sformatf("badvaddr_o[%0d]", i), 64'(exp_bad_i[i]),
                          64'(badvaddr_i[i]));
            end
            check_val("mem_rd_o", 64'(exp_rd_i), 64'(mem_rd_i));
            check_val("mem_wr_o", 64'(exp_wr_i), 64'(mem_wr_i));
            check_val("redirect_o", 64'(exp_redir_i), 64'(redirect_i));
            check_val("redirect_pc_o", 64'(exp_rpc_i), 64'(redirect_pc_i));
            check_val("hilo_we_o", 64'(exp_hwe_i), 64'(hilo_we_i));
            if (exp_hwe_i) begin
                check_val("hilo_o", exp_hilo_i, hilo_i);
            end
        end else begin
            // control outputs stay quiet on an idle pair
            stall_cnt = 0;
            check_val("res_valid_o idle", 64'(2'b00), 64'(res_valid_i));
            check_val("mem_rd_o idle", 64'(2'b00), 64'(mem_rd_i));
            check_val("mem_wr_o idle", 64'(2'b00), 64'(mem_wr_i));
            check_val("redirect_o idle", 64'(1'b0), 64'(redirect_i));
            check_val("hilo_we_o idle", 64'(1'b0), 64'(hilo_we_i));
        end
    end

endmodule

`default_nettype wire

// File: verification/exec_stim.txt
# vld op1 op0 rs1 rs0 rt1 rt0 imm1 imm0 sh1 sh0 pc jidx pred (inputs, hex)
# rvld d1 d0 rd wr exc1 exc0 bad1 bad0 redir rpc stall_cycles(dec) hwe hilo (expected)
3 01 03 5 a 7 3 0 0 0 0 0 0 0 3 c 7 0 0 0 0 0 0 0 0 0 0 0
3 0e 10 10 ffffffff 0 0 fff0 8001 0 0 0 0 0 3 0 8001 0 0 0 0 0 0 0 0 0 0 0
3 11 12 12340000 ffff0000 0 0 5678 ffff 0 0 0 0 0 3 12345678 ffffffff 0 0 0 0 0 0 0 0 0 0 0
3 09 0a ffffffff ffffffff 1 1 0 0 0 0 0 0 0 3 1 0 0 0 0 0 0 0 0 0 0 0 0
3 13 14 5 0 0 0 ffff abcd 0 0 0 0 0 3 0 abcd0000 0 0 0 0 0 0 0 0 0 0 0
3 0b 0d 0 0 1 80000000 0 0 1f 4 0 0 0 3 80000000 f8000000 0 0 0 0 0 0 0 0 0 0 0
3 0c 08 0 0f0f0f0f 80000000 f0f00000 0 0 4 0 0 0 0 3 08000000 0000f0f0 0 0 0 0 0 0 0 0 0 0 0
3 01 02 7fffffff 1 1 2 0 0 0 0 0 0 0 2 80000000 3 0 0 1 0 0 0 0 0 0 0 0
3 05 03 ffffffff 80000000 00ff00ff 1 0 0 0 0 0 0 0 3 00ff00ff 7fffffff 0 0 0 1 0 0 0 0 0 0 0
3 15 18 1000 2000 0 0 2 0 0 0 0 0 0 3 1002 2000 0 0 2 0 1002 0 0 0 0 0 0
3 19 16 3001 4000 0 0 0 2 0 0 0 0 0 3 3001 4002 0 0 3 0 3001 0 0 0 0 0 0
3 15 1a 1000 5001 0 0 4 0 0 0 0 0 0 3 1004 5001 2 1 0 0 0 0 0 0 0 0 0
3 17 16 0 0 0 0 3 5 0 0 0 0 0 3 3 5 2 0 0 2 0 5 0 0 0 0 0
2 1b 00 5 0 5 0 0004 0 0 0 00400000 0 0 2 0 0 0 0 0 0 0 0 1 00400014 0 0 0
2 1c 00 5 0 5 0 0 0 0 0 00400100 0 1 2 0 0 0 0 0 0 0 0 1 00400108 0 0 0
2 1d 00 80000000 0 0 0 fffe 0 0 0 00400200 0 1 2 0 0 0 0 0 0 0 0 0 0 0 0 0
2 1e 00 1 0 0 0 fffc 0 0 0 00400300 0 0 2 0 0 0 0 0 0 0 0 1 004002f4 0 0 0
2 1b 00 1 0 2 0 0010 0 0 0 00400400 0 0 2 0 0 0 0 0 0 0 0 0 0 0 0 0
2 21 00 00801234 0 0 0 0 0 0 0 00400400 0 0 2 0 0 0 0 0 0 0 0 1 00801234 0 0 0
2 20 00 0 0 0 0 0 0 0 0 10000ffc 0123456 0 2 10001004 0 0 0 0 0 0 0 1 1048d158 0 0 0
2 1f 00 0 0 0 0 0 0 0 0 00400500 0 1 2 0 0 0 0 0 0 0 0 0 0 0 0 0
3 22 02 fffffffd 2 7 3 0 0 0 0 0 0 0 3 0 5 0 0 0 0 0 0 0 0 33 1 ffffffffffffffeb
1 00 23 0 ffffffff 0 2 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 33 1 00000001fffffffe
2 24 00 fffffff9 0 2 0 0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 0 0 0 33 1 fffffffffffffffd
2 25 00 d 0 0 0 0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 0 0 0 33 1 0000000dffffffff
3 07 24 ff00ff00 fffffffb 0f0f0f0f 0 0 0 0 0 0 0 0 3 f00ff00f 0 0 0 0 0 0 0 0 0 33 1 fffffffb00000001

// File: verification/tb_exec_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tb_exec_stage;
    import exec_pkg::*;

    localparam int MAX_LINES = 64;
    localparam int CLK_NS = 8;

    logic clk;
    logic rst_n_i;
    logic [1:0] iss_valid_i;
    op_e [1:0] iss_op_i;
    word_t [1:0] iss_rs_i;
    word_t [1:0] iss_rt_i;
    logic [1:0][15:0] iss_imm_i;
    logic [1:0][4:0] iss_shamt_i;
    word_t iss_pc_i;
    logic [25:0] iss_jidx_i;
    logic iss_pred_taken_i;
    logic [1:0] res_valid_o;
    word_t [1:0] res_data_o;
    logic [1:0] mem_rd_o;
    logic [1:0] mem_wr_o;
    exc_e [1:0] exc_o;
    word_t [1:0] badvaddr_o;
    logic redirect_o;
    word_t redirect_pc_o;
    logic hilo_we_o;
    dword_t hilo_o;
    logic stall_o;

    // one entry per stim line
    logic [1:0] vld_a[MAX_LINES];
    logic [5:0] op1_a[MAX_LINES];
    logic [5:0] op0_a[MAX_LINES];
    word_t rs1_a[MAX_LINES];
    word_t rs0_a[MAX_LINES];
    word_t rt1_a[MAX_LINES];
    word_t rt0_a[MAX_LINES];
    logic [15:0] imm1_a[MAX_LINES];
    logic [15:0] imm0_a[MAX_LINES];
    logic [4:0] sh1_a[MAX_LINES];
    logic [4:0] sh0_a[MAX_LINES];
    word_t pc_a[MAX_LINES];
    logic [25:0] jidx_a[MAX_LINES];
    logic pred_a[MAX_LINES];
    logic [1:0] rvld_a[MAX_LINES];
    word_t d1_a[MAX_LINES];
    word_t d0_a[MAX_LINES];
    logic [1:0] rd_a[MAX_LINES];
    logic [1:0] wr_a[MAX_LINES];
    logic [1:0] exc1_a[MAX_LINES];
    logic [1:0] exc0_a[MAX_LINES];
    word_t bad1_a[MAX_LINES];
    word_t bad0_a[MAX_LINES];
    logic redir_a[MAX_LINES];
    word_t rpc_a[MAX_LINES];
    int stl_a[MAX_LINES];
    logic hwe_a[MAX_LINES];
    dword_t hilo_a[MAX_LINES];

    int n_lines = 0;
    int file_errs = 0;
    int cur = 0;
    int err_cnt;
    logic chk_en = 1'b0;
    logic loaded = 1'b0;

    exec_stage DUT (.*);

    exec_checker u_checker (
        .clk(clk), .rst_n_i(rst_n_i), .chk_en_i(chk_en),
        .exp_valid_i(rvld_a[cur]), .exp_data_i({d1_a[cur], d0_a[cur]}),
        .exp_rd_i(rd_a[cur]), .exp_wr_i(wr_a[cur]),
        .exp_exc_i({exc1_a[cur], exc0_a[cur]}), .exp_bad_i({bad1_a[cur], bad0_a[cur]}),
        .exp_redir_i(redir_a[cur]), .exp_rpc_i(rpc_a[cur]), .exp_stall_i(stl_a[cur]),
        .exp_hwe_i(hwe_a[cur]), .exp_hilo_i(hilo_a[cur]),
        .res_valid_i(res_valid_o), .res_data_i(res_data_o), .mem_rd_i(mem_rd_o),
        .mem_wr_i(mem_wr_o), .exc_i(exc_o), .badvaddr_i(badvaddr_o),
        .redirect_i(redirect_o), .redirect_pc_i(redirect_pc_o), .hilo_we_i(hilo_we_o),
        .hilo_i(hilo_o), .stall_i(stall_o), .err_cnt_o(err_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    task automatic load_stim();
        int fd;
        int nf;
        string line;
        fd = $fopen("verification/exec_stim.txt", "r");
        if (fd == 0) begin
            $display("stimulus file verification/exec_stim.txt could not be opened");
            file_errs++;
            return;
        end
        while (!$feof(fd) && n_lines < MAX_LINES) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 4 || line[0] == "#") begin
                continue;
            end
            nf = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d %h %h",
                vld_a[n_lines], op1_a[n_lines], op0_a[n_lines], rs1_a[n_lines],
                rs0_a[n_lines], rt1_a[n_lines], rt0_a[n_lines], imm1_a[n_lines],
                imm0_a[n_lines], sh1_a[n_lines], sh0_a[n_lines], pc_a[n_lines],
                jidx_a[n_lines], pred_a[n_lines], rvld_a[n_lines], d1_a[n_lines],
                d0_a[n_lines], rd_a[n_lines], wr_a[n_lines], exc1_a[n_lines],
                exc0_a[n_lines], bad1_a[n_lines], bad0_a[n_lines], redir_a[n_lines],
                rpc_a[n_lines], stl_a[n_lines], hwe_a[n_lines], hilo_a[n_lines]);
            if (nf != 28) begin
                $display("stimulus line after entry %0d has %0d fields", n_lines, nf);
                file_errs++;
            end else begin
                n_lines++;
            end
        end
        $fclose(fd);
        if (n_lines == 0) begin
            $display("stimulus file holds no usable lines");
            file_errs++;
        end
    endtask

    task automatic drive_line(int k);
        iss_valid_i = vld_a[k];
        iss_op_i[1] = op_e'(op1_a[k]);
        iss_op_i[0] = op_e'(op0_a[k]);
        iss_rs_i = {rs1_a[k], rs0_a[k]};
        iss_rt_i = {rt1_a[k], rt0_a[k]};
        iss_imm_i = {imm1_a[k], imm0_a[k]};
        iss_shamt_i = {sh1_a[k], sh0_a[k]};
        iss_pc_i = pc_a[k];
        iss_jidx_i = jidx_a[k];
        iss_pred_taken_i = pred_a[k];
    endtask

    // inputs move while stalled and the latch ignores them
    task automatic drive_junk();
        iss_valid_i = 2'b11;
        iss_op_i[1] = ADD;
        iss_op_i[0] = SUB;
        iss_rs_i[1] = ~iss_rs_i[1];
        iss_rt_i[0] = iss_rt_i[0] + 32'd1;
        iss_pc_i = iss_pc_i + 32'd4;
        iss_pred_taken_i = ~iss_pred_taken_i;
    endtask

    task automatic drive_idle();
        iss_valid_i = 2'b00;
        iss_op_i[1] = OP_NOP;
        iss_op_i[0] = OP_NOP;
        iss_rs_i = '0;
        iss_rt_i = '0;
        iss_imm_i = '0;
        iss_shamt_i = '0;
        iss_pc_i = '0;
        iss_jidx_i = '0;
        iss_pred_taken_i = 1'b0;
    endtask

    initial begin
        longint limit_ns;
        wait (loaded);
        limit_ns = longint'(n_lines + 4) * (MULDIV_STEPS + 4) * CLK_NS;
        #(limit_ns);
        $display("timeout: run still busy after %0d ns", limit_ns);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst_n_i = 1'b0;
        drive_idle();
        load_stim();
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        for (int k = 0; k < n_lines; k++) begin
            drive_line(k);
            @(negedge clk);
            cur = k;
            chk_en = 1'b1;
            while (stall_o) begin
                drive_junk();
                @(negedge clk);
            end
        end
        drive_idle();
        @(negedge clk);
        chk_en = 1'b0;
        repeat (3) @(negedge clk);
        $display("errors: %0d in checks, %0d in stimulus", err_cnt, file_errs);
        if (err_cnt == 0 && file_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
